// ==== source/lsu_macros.svh ====
// Global sizes for the load/store path
// Data memory is a flat array of doubleword lines, no banking
// Changing DMEM_WORDS must keep it a power of two, addresses wrap
// TAG_W only sizes the tag, tags are not checked for reuse

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// ------------------------------
// Datapath
// ------------------------------
`define XLEN 64

// Bytes per line give the offset width
`define BYTE_OFF_W ($clog2(`XLEN / 8))

// ------------------------------
// Data memory and tags
// ------------------------------
`define DMEM_WORDS 256
`define DMEM_IDX_W ($clog2(`DMEM_WORDS))
`define TAG_W 5

`endif

// ==== source/memory_pkg.sv ====
// Types that describe a data memory access
// Width encoding follows the load/store unit of the core
// A request carries one doubleword lane set, no bursts

`include "lsu_macros.svh"

package memory_pkg;

    // Access size, unsigned variants only matter for loads
    typedef enum logic [2:0] {
        LS_BYTE,
        LS_BYTE_U,
        LS_HALFWORD,
        LS_HALFWORD_U,
        LS_WORD,
        LS_WORD_U,
        LS_DOUBLEWORD
    } ldst_width_t;

    // Direction of the access
    typedef enum logic {
        LSU_LOAD,
        LSU_STORE
    } ldst_op_t;

    // ------------------------------
    // Request to the data memory
    // ------------------------------
    typedef struct packed {
        logic [`DMEM_IDX_W-1:0] line_idx;  // doubleword line
        logic [`BYTE_OFF_W-1:0] byte_off;  // first byte in line
        ldst_width_t            width;
        ldst_op_t               op;
        logic [`XLEN-1:0]       wdata;     // store data, right aligned
        logic                   we;        // aligned store only
    } dmem_req_t;

endpackage

// ==== source/expipe_pkg.sv ====
// Types that travel between the load/store pipeline stages
// Payloads are only meaningful while the matching valid is high
// Depends on memory_pkg, compile that first

`include "lsu_macros.svh"

package expipe_pkg;

    // ------------------------------
    // Issued operation
    // ------------------------------
    typedef struct packed {
        memory_pkg::ldst_op_t    op;
        memory_pkg::ldst_width_t width;
        logic [`XLEN-1:0]        base;   // base register value
        logic [`XLEN-1:0]        imm;    // already sign extended
        logic [`XLEN-1:0]        sdata;  // store data
        logic [`TAG_W-1:0]       tag;    // destination tag
    } lsu_op_t;

    // Address stage output
    typedef struct packed {
        memory_pkg::dmem_req_t req;
        logic [`TAG_W-1:0]     tag;
        logic                  exc;  // misaligned access
    } agu_stage_t;

    // ------------------------------
    // Memory stage output
    // ------------------------------
    // Full line, byte selection is left to writeback
    typedef struct packed {
        logic [`XLEN-1:0]        line;
        logic [`BYTE_OFF_W-1:0]  byte_off;
        memory_pkg::ldst_width_t width;
        memory_pkg::ldst_op_t    op;
        logic [`TAG_W-1:0]       tag;
        logic                    exc;
    } mem_stage_t;

    // Final result, data is zero for stores and exceptions
    typedef struct packed {
        logic [`TAG_W-1:0]    tag;
        memory_pkg::ldst_op_t op;
        logic                 exc;
        logic [`XLEN-1:0]     data;
    } lsu_result_t;

endpackage

// ==== source/byte_selector.sv ====
// Picks the addressed byte, halfword or word out of a doubleword line
// Purely combinational
// Offset is assumed aligned to the width, misaligned ops are flagged
// upstream and their output here is meaningless
// Doubleword and unknown widths pass the line through

`timescale 1ns/1ns
`include "lsu_macros.svh"

module byte_selector (
    input  memory_pkg::ldst_width_t type_i,
    input  logic [`BYTE_OFF_W-1:0]  byte_off_i,
    input  logic [`XLEN-1:0]        data_i,
    output logic [`XLEN-1:0]        data_o
);

    logic [31:0] sel_word;
    logic [15:0] sel_half;
    logic [7:0]  sel_byte;

    // ------------------------------
    // Selection tree
    // ------------------------------
    // One mux level per offset bit, high bit first
    always_comb begin
        // Upper or lower word
        sel_word = byte_off_i[2] ? data_i[63:32] : data_i[31:0];
        // Halfword within that word
        sel_half = byte_off_i[1] ? sel_word[31:16] : sel_word[15:0];
        // Byte within that halfword
        sel_byte = byte_off_i[0] ? sel_half[15:8] : sel_half[7:0];
    end

    // ------------------------------
    // Extension
    // ------------------------------
    always_comb begin
        case (type_i)
            // Bytes
            memory_pkg::LS_BYTE:
                data_o = {{(`XLEN-8){sel_byte[7]}}, sel_byte};
            memory_pkg::LS_BYTE_U:
                data_o = {{(`XLEN-8){1'b0}}, sel_byte};
            // Halfwords
            memory_pkg::LS_HALFWORD:
                data_o = {{(`XLEN-16){sel_half[15]}}, sel_half};
            memory_pkg::LS_HALFWORD_U:
                data_o = {{(`XLEN-16){1'b0}}, sel_half};
            // Words
            memory_pkg::LS_WORD:
                data_o = {{(`XLEN-32){sel_word[31]}}, sel_word};
            memory_pkg::LS_WORD_U:
                data_o = {{(`XLEN-32){1'b0}}, sel_word};
            // Full line
            memory_pkg::LS_DOUBLEWORD:
                data_o = data_i;
            default:
                data_o = data_i;
        endcase
    end

endmodule

// ==== source/address_gen.sv ====
// Address generation, one cycle
// Effective address is base + imm, bits above the memory depth dropped
// Only place where alignment is checked, later stages trust exc and we
// No back-pressure, a new operation may enter every cycle

`timescale 1ns/1ns
`include "lsu_macros.svh"

module address_gen (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  expipe_pkg::lsu_op_t    op_i,
    output logic                   valid_o,
    output expipe_pkg::agu_stage_t stage_o
);

    logic [`XLEN-1:0]       eff_addr;
    logic [`BYTE_OFF_W-1:0] byte_off;
    logic                   misaligned;
    expipe_pkg::agu_stage_t stage_d;
    expipe_pkg::agu_stage_t stage_q;
    logic                   valid_q;

    // ------------------------------
    // Address and alignment
    // ------------------------------
    assign eff_addr = op_i.base + op_i.imm;
    assign byte_off = eff_addr[`BYTE_OFF_W-1:0];

    always_comb begin
        case (op_i.width)
            // Halfword needs an even offset
            memory_pkg::LS_HALFWORD, memory_pkg::LS_HALFWORD_U:
                misaligned = byte_off[0];
            // Word on a four byte boundary
            memory_pkg::LS_WORD, memory_pkg::LS_WORD_U:
                misaligned = |byte_off[1:0];
            memory_pkg::LS_DOUBLEWORD:
                misaligned = |byte_off;
            // Bytes are always aligned
            default:
                misaligned = 1'b0;
        endcase
    end

    // Split address into line and offset
    always_comb begin
        stage_d.req.line_idx = eff_addr[`BYTE_OFF_W +: `DMEM_IDX_W];
        stage_d.req.byte_off = byte_off;
        stage_d.req.width    = op_i.width;
        stage_d.req.op       = op_i.op;
        stage_d.req.wdata    = op_i.sdata;
        // Misaligned stores must not touch memory
        stage_d.req.we       = (op_i.op == memory_pkg::LSU_STORE) && !misaligned;
        stage_d.tag          = op_i.tag;
        stage_d.exc          = misaligned;
    end

    // ------------------------------
    // Stage registers
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // Payload only moves with a valid op
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            stage_q <= stage_d;
        end
    end

    assign valid_o = valid_q;
    assign stage_o = stage_q;

endmodule

// ==== source/dmem_stage.sv ====
// Data memory stage, one cycle
// Synchronous single-port style array of DMEM_WORDS doubleword lines
// Store write and load read share the edge, a store is visible one cycle later
// Contents are not reset, reading unwritten lines gives X in simulation
// Write enable comes from address_gen, alignment is not rechecked here

`timescale 1ns/1ns
`include "lsu_macros.svh"

module dmem_stage (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  expipe_pkg::agu_stage_t req_i,
    output logic                   valid_o,
    output expipe_pkg::mem_stage_t stage_o
);

    // Byte lanes per line
    localparam int unsigned LANES = `XLEN / 8;

    logic [`XLEN-1:0]       mem_q [`DMEM_WORDS];
    logic [LANES-1:0]       base_mask;
    logic [LANES-1:0]       lane_mask;
    logic [`XLEN-1:0]       store_data;
    expipe_pkg::mem_stage_t stage_q;
    logic                   valid_q;

    // ------------------------------
    // Lane mask and data shift
    // ------------------------------
    // Mask anchored at lane 0, then moved to the offset
    always_comb begin
        case (req_i.req.width)
            memory_pkg::LS_BYTE, memory_pkg::LS_BYTE_U:
                base_mask = LANES'(8'h01);
            memory_pkg::LS_HALFWORD, memory_pkg::LS_HALFWORD_U:
                base_mask = LANES'(8'h03);
            memory_pkg::LS_WORD, memory_pkg::LS_WORD_U:
                base_mask = LANES'(8'h0F);
            default:
                base_mask = '1;
        endcase
    end

    assign lane_mask = base_mask << req_i.req.byte_off;

    // Store data right aligned, shift by offset times eight
    assign store_data = req_i.req.wdata << {req_i.req.byte_off, 3'b000};

    // ------------------------------
    // Memory array
    // ------------------------------
    // Byte-enable write, untouched lanes keep their value
    always_ff @(posedge clk_i) begin
        if (valid_i && req_i.req.we) begin
            for (int b = 0; b < LANES; b++) begin
                if (lane_mask[b]) begin
                    mem_q[req_i.req.line_idx][b*8 +: 8] <= store_data[b*8 +: 8];
                end
            end
        end
    end

    // Line read for every op, old data when the op is a store
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            stage_q.line     <= mem_q[req_i.req.line_idx];
            stage_q.byte_off <= req_i.req.byte_off;
            stage_q.width    <= req_i.req.width;
            stage_q.op       <= req_i.req.op;
            stage_q.tag      <= req_i.tag;
            stage_q.exc      <= req_i.exc;
        end
    end

    // Valid strobe
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    assign valid_o = valid_q;
    assign stage_o = stage_q;

endmodule

// ==== source/load_writeback.sv ====
// Writeback stage, one cycle
// Extracts load data from the raw line and registers the result
// Data is zero for stores and for any excepted op
// Consumer must take every result, there is no stall

`timescale 1ns/1ns
`include "lsu_macros.svh"

module load_writeback (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    valid_i,
    input  expipe_pkg::mem_stage_t  stage_i,
    output logic                    valid_o,
    output expipe_pkg::lsu_result_t result_o
);

    logic [`XLEN-1:0]        sel_data;
    logic                    keep_data;
    expipe_pkg::lsu_result_t result_q;
    logic                    valid_q;

    // Byte selection and extension
    byte_selector u_byte_selector (
        .type_i     (stage_i.width),
        .byte_off_i (stage_i.byte_off),
        .data_i     (stage_i.line),
        .data_o     (sel_data)
    );

    // Only aligned loads return data
    assign keep_data = (stage_i.op == memory_pkg::LSU_LOAD) && !stage_i.exc;

    // ------------------------------
    // Result registers
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            result_q.tag  <= stage_i.tag;
            result_q.op   <= stage_i.op;
            result_q.exc  <= stage_i.exc;
            result_q.data <= keep_data ? sel_data : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    assign valid_o  = valid_q;
    assign result_o = result_q;

endmodule

// ==== source/load_store_pipe.sv ====
// Load/store execution path, top level
// Fixed latency of three cycles from valid_i to valid_o
// Up to three ops in flight, results leave in issue order
// No handshake, valid_i may be high every cycle
// Misaligned ops raise exc, stores then write nothing, loads return zero

`timescale 1ns/1ns

module load_store_pipe (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    valid_i,
    input  expipe_pkg::lsu_op_t     op_i,
    output logic                    valid_o,
    output expipe_pkg::lsu_result_t result_o
);

    // ------------------------------
    // Inter-stage wires
    // ------------------------------
    logic                   agu_valid;
    expipe_pkg::agu_stage_t agu_q;
    logic                   mem_valid;
    expipe_pkg::mem_stage_t mem_q;

    // Address generation and alignment
    address_gen u_address_gen (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (valid_i),
        .op_i    (op_i),
        .valid_o (agu_valid),
        .stage_o (agu_q)
    );

    // Data memory access
    dmem_stage u_dmem_stage (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (agu_valid),
        .req_i   (agu_q),
        .valid_o (mem_valid),
        .stage_o (mem_q)
    );

    // Byte select and result
    load_writeback u_load_writeback (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .valid_i  (mem_valid),
        .stage_i  (mem_q),
        .valid_o  (valid_o),
        .result_o (result_o)
    );

endmodule

// ==== tests/load_store_pipe_checker.sv ====
// Port assertions for load_store_pipe, bound into every instance
// Assumes the fixed latency of three cycles
// fail_count lets the testbench see assertion failures

`timescale 1ns/1ns

module load_store_pipe_checker (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input logic                    valid_i,
    input expipe_pkg::lsu_op_t     op_i,
    input logic                    valid_o,
    input expipe_pkg::lsu_result_t result_o
);

    int fail_count = 0;

    // No result after an edge with reset low
    reset_quiet: assert property (@(posedge clk_i) !rst_n_i |=> !valid_o)
        else begin
            fail_count++;
            $error("valid_o high after a reset cycle");
        end

    // Fixed three cycle latency
    latency_three: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o == $past(valid_i, 3))
        else begin
            fail_count++;
            $error("valid_o does not follow valid_i by three cycles");
        end

    exc_zero_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_o && result_o.exc) |-> result_o.data == '0)
        else begin
            fail_count++;
            $error("Excepted op returned nonzero data");
        end

    op_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i |-> !$isunknown(op_i))
        else begin
            fail_count++;
            $error("op_i has unknown bits while valid_i is high");
        end

endmodule

bind load_store_pipe load_store_pipe_checker u_checker (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (valid_i),
    .op_i     (op_i),
    .valid_o  (valid_o),
    .result_o (result_o)
);

// ==== tests/tb_load_store_pipe.sv ====
// Testbench for the load/store pipe, self-checking against a shadow memory
// Shadow memory follows every aligned store in issue order
// Lines 0 to 31 are written first, reads of unwritten lines would give X
// Random burst stays within lines 0 to 15, upper address bits are random

`timescale 1ns/1ns
`include "lsu_macros.svh"

module tb_load_store_pipe;

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 10;
    localparam int INIT_LINES   = 32;
    localparam int N_RANDOM     = 300;
    // Upper bound on directed ops, readback of init lines included
    localparam int N_DIRECTED   = 160;
    localparam int N_PHASES     = 7;
    localparam int TOTAL_OPS    = INIT_LINES + N_DIRECTED + N_RANDOM;
    // Reset, one cycle per op, drain per phase, margin
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_OPS + N_PHASES * 10 + 20;

    logic                    clk;
    logic                    rst_n;
    logic                    valid_in;
    expipe_pkg::lsu_op_t     op_in;
    logic                    valid_out;
    expipe_pkg::lsu_result_t result;

    logic [`XLEN-1:0]        shadow [`DMEM_WORDS];
    expipe_pkg::lsu_result_t exp_q [$];
    string                   name_q [$];
    int                      edge_q [$];
    expipe_pkg::lsu_result_t exp_r;
    string                   exp_name;
    int                      exp_edge;
    string                   test_name;
    logic [63:0]             rng_state;
    int                      cycle = 0;
    int                      tag_count;
    int                      n_checked;
    int                      value_errors;
    int                      proto_errors;
    int                      assert_fails;

    load_store_pipe uut (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .valid_i  (valid_in),
        .op_i     (op_in),
        .valid_o  (valid_out),
        .result_o (result)
    );

    // ------------------------------
    // Clock and cycle count
    // ------------------------------
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [63:0] xorshift64(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    function automatic logic [63:0] next_random();
        rng_state = xorshift64(rng_state);
        return rng_state;
    endfunction

    // Access size in bytes
    function automatic int width_bytes(input memory_pkg::ldst_width_t w);
        case (w)
            memory_pkg::LS_BYTE, memory_pkg::LS_BYTE_U:         return 1;
            memory_pkg::LS_HALFWORD, memory_pkg::LS_HALFWORD_U: return 2;
            memory_pkg::LS_WORD, memory_pkg::LS_WORD_U:         return 4;
            default:                                            return 8;
        endcase
    endfunction

    function automatic bit is_signed_width(input memory_pkg::ldst_width_t w);
        return w == memory_pkg::LS_BYTE || w == memory_pkg::LS_HALFWORD ||
               w == memory_pkg::LS_WORD;
    endfunction

    // Line and offset from the byte address, wraps at the memory size
    function automatic int line_of(input logic [63:0] addr);
        return int'((addr / 8) % `DMEM_WORDS);
    endfunction

    // Pattern mixes every address bit
    function automatic logic [63:0] fill_pattern(input logic [63:0] addr);
        return {addr[63:32] ^ addr[31:0] ^ 32'hC3A5_5A3C, ~addr[31:0]};
    endfunction

    // Expected result of one op, read before its own store is applied
    function automatic expipe_pkg::lsu_result_t expected_result(input expipe_pkg::lsu_op_t op);
        logic [63:0]             addr;
        logic [63:0]             raw;
        logic [63:0]             mask;
        int                      off;
        int                      size;
        expipe_pkg::lsu_result_t r;
        addr   = op.base + op.imm;
        off    = int'(addr[2:0]);
        size   = width_bytes(op.width);
        r.tag  = op.tag;
        r.op   = op.op;
        r.exc  = (off % size) != 0;
        r.data = '0;
        if (op.op == memory_pkg::LSU_LOAD && !r.exc) begin
            raw = shadow[line_of(addr)] >> (8 * off);
            if (size < 8) begin
                mask = (64'd1 << (8 * size)) - 64'd1;
                raw  = raw & mask;
                // Copy the top loaded bit upward for signed widths
                if (is_signed_width(op.width) && raw[8 * size - 1]) begin
                    raw = raw | ~mask;
                end
            end
            r.data = raw;
        end
        return r;
    endfunction

    // Aligned stores write size bytes from the low end of sdata
    task automatic update_shadow(input expipe_pkg::lsu_op_t op);
        logic [63:0] addr;
        int          off;
        int          size;
        addr = op.base + op.imm;
        off  = int'(addr[2:0]);
        size = width_bytes(op.width);
        if (op.op == memory_pkg::LSU_STORE && (off % size) == 0) begin
            for (int b = 0; b < size; b++) begin
                shadow[line_of(addr)][8 * (off + b) +: 8] = op.sdata[8 * b +: 8];
            end
        end
    endtask

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    // Called 10 ns after a rising edge, returns at the same phase
    task automatic issue(input expipe_pkg::lsu_op_t op);
        exp_q.push_back(expected_result(op));
        name_q.push_back(test_name);
        edge_q.push_back(cycle + 1);
        update_shadow(op);
        tag_count++;
        valid_in = 1'b1;
        op_in    = op;
        @(posedge clk);
        #10;
        valid_in = 1'b0;
    endtask

    // Base and imm chosen so that their sum is addr
    task automatic access(input memory_pkg::ldst_op_t kind, input memory_pkg::ldst_width_t width,
                          input logic [63:0] addr, input logic [63:0] data,
                          input logic [63:0] split);
        expipe_pkg::lsu_op_t op;
        op.op    = kind;
        op.width = width;
        op.base  = addr - split;
        op.imm   = split;
        op.sdata = data;
        op.tag   = tag_count[`TAG_W-1:0];
        issue(op);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    // Wait until every issued op has come back
    task automatic drain();
        while (exp_q.size() != 0) begin
            idle(1);
        end
        idle(2);
    endtask

    // ------------------------------
    // Compare
    // ------------------------------
    // Outputs settle after the rising edge, sample on the falling one
    always @(negedge clk) begin
        if (rst_n && valid_out === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("valid_o went high at cycle %0d with no op outstanding", cycle);
                proto_errors++;
            end else begin
                exp_r    = exp_q.pop_front();
                exp_name = name_q.pop_front();
                exp_edge = edge_q.pop_front();
                n_checked++;
                // Consumer takes the result at the next rising edge
                if (cycle + 1 != exp_edge + 3) begin
                    $display("** Error %s: result edge expected %0d, actual %0d",
                             exp_name, exp_edge + 3, cycle + 1);
                    value_errors++;
                end
                if (result.tag !== exp_r.tag) begin
                    $display("** Error %s: tag expected %0h, actual %0h",
                             exp_name, exp_r.tag, result.tag);
                    value_errors++;
                end
                if (result.op !== exp_r.op) begin
                    $display("** Error %s: op expected %0d, actual %0d (tag %0h)",
                             exp_name, exp_r.op, result.op, exp_r.tag);
                    value_errors++;
                end
                if (result.exc !== exp_r.exc) begin
                    $display("** Error %s: exc expected %0b, actual %0b (tag %0h)",
                             exp_name, exp_r.exc, result.exc, exp_r.tag);
                    value_errors++;
                end
                if (result.data !== exp_r.data) begin
                    $display("** Error %s: data expected %h, actual %h (tag %0h)",
                             exp_name, exp_r.data, result.data, exp_r.tag);
                    value_errors++;
                end
            end
        end else if (rst_n && valid_out !== 1'b0) begin
            $display("valid_o is unknown at cycle %0d", cycle);
            proto_errors++;
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * PERIOD);
        $display("Run timed out after %0d cycles with %0d results still outstanding",
                 TIMEOUT_CYCLES, exp_q.size());
        $display("Verification failed");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        memory_pkg::ldst_width_t width;
        logic [63:0]             rnd;
        logic [63:0]             hi;
        logic [63:0]             addr;
        int                      size;
        valid_in     = 1'b0;
        op_in        = '0;
        rst_n        = 1'b0;
        rng_state    = 64'd99;
        tag_count    = 0;
        n_checked    = 0;
        value_errors = 0;
        proto_errors = 0;
        test_name    = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // Quiet after reset, then exact latency of a lone op
        test_name = "latency";
        idle(5);
        if (valid_out !== 1'b0 || n_checked != 0) begin
            $display("valid_o not low after reset with nothing issued");
            proto_errors++;
        end
        access(memory_pkg::LSU_STORE, memory_pkg::LS_DOUBLEWORD, 64'd0,
               fill_pattern(64'd0), 64'd40);
        idle(2);
        if (exp_q.size() != 1) begin
            $display("Result of the first op came back in fewer than three cycles");
            proto_errors++;
        end
        drain();

        // Known contents for every line the tests read
        test_name = "init";
        for (int l = 0; l < INIT_LINES; l++) begin
            addr = 64'(l * 8);
            access(memory_pkg::LSU_STORE, memory_pkg::LS_DOUBLEWORD, addr,
                   fill_pattern(addr), 64'd40);
        end
        for (int l = 0; l < INIT_LINES; l++) begin
            access(memory_pkg::LSU_LOAD, memory_pkg::LS_DOUBLEWORD, 64'(l * 8), '0, 64'd40);
        end
        drain();

        // Every width at every legal offset in line 20
        test_name = "round_trip";
        for (int w = 0; w < 7; w++) begin
            width = memory_pkg::ldst_width_t'(w);
            size  = width_bytes(width);
            for (int off = 0; off < 8; off += size) begin
                rnd = next_random();
                access(memory_pkg::LSU_STORE, width, 64'(160 + off), rnd, 64'd40);
                access(memory_pkg::LSU_LOAD, width, 64'(160 + off), '0, 64'd40);
            end
        end
        drain();

        // All bytes have the top bit set
        test_name = "sign_extend";
        access(memory_pkg::LSU_STORE, memory_pkg::LS_DOUBLEWORD, 64'd168,
               64'hF1E2_D3C4_B5A6_9788, 64'd40);
        for (int w = 0; w < 6; w++) begin
            width = memory_pkg::ldst_width_t'(w);
            size  = width_bytes(width);
            for (int off = 0; off < 8; off += size) begin
                access(memory_pkg::LSU_LOAD, width, 64'(168 + off), '0, 64'd40);
            end
        end
        drain();

        // Misaligned ops in line 22, high address bits wrap away
        test_name = "misaligned";
        hi = 64'hDEAD_0000_0000_0000;
        access(memory_pkg::LSU_STORE, memory_pkg::LS_DOUBLEWORD, hi + 176,
               64'h0123_4567_89AB_CDEF, 64'd40);
        access(memory_pkg::LSU_STORE, memory_pkg::LS_HALFWORD, hi + 177, '1, 64'd40);
        access(memory_pkg::LSU_STORE, memory_pkg::LS_WORD, hi + 178, '1, 64'd40);
        access(memory_pkg::LSU_STORE, memory_pkg::LS_DOUBLEWORD, hi + 180, '1, 64'd40);
        access(memory_pkg::LSU_LOAD, memory_pkg::LS_HALFWORD_U, hi + 179, '0, 64'd40);
        access(memory_pkg::LSU_LOAD, memory_pkg::LS_WORD, hi + 182, '0, 64'd40);
        access(memory_pkg::LSU_LOAD, memory_pkg::LS_DOUBLEWORD, hi + 177, '0, 64'd40);
        // Line must still hold the first store
        access(memory_pkg::LSU_LOAD, memory_pkg::LS_DOUBLEWORD, 64'd176, '0, 64'd40);
        drain();

        // Load right behind a store, partial writes keep neighbours
        test_name = "store_to_load";
        access(memory_pkg::LSU_STORE, memory_pkg::LS_DOUBLEWORD, 64'd184,
               64'h1111_2222_3333_4444, 64'd40);
        access(memory_pkg::LSU_STORE, memory_pkg::LS_BYTE, 64'd187, 64'hAB, 64'd40);
        access(memory_pkg::LSU_LOAD, memory_pkg::LS_DOUBLEWORD, 64'd184, '0, 64'd40);
        access(memory_pkg::LSU_STORE, memory_pkg::LS_HALFWORD_U, 64'd190, 64'hBEEF, 64'd40);
        access(memory_pkg::LSU_LOAD, memory_pkg::LS_WORD_U, 64'd188, '0, 64'd40);
        access(memory_pkg::LSU_STORE, memory_pkg::LS_WORD, 64'd184, 64'hCAFE_F00D, 64'd40);
        access(memory_pkg::LSU_LOAD, memory_pkg::LS_DOUBLEWORD, 64'd184, '0, 64'd40);
        access(memory_pkg::LSU_LOAD, memory_pkg::LS_BYTE_U, 64'd186, '0, 64'd40);
        drain();

        // Back-to-back random ops on lines 0 to 15
        test_name = "random";
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd   = next_random();
            hi    = next_random();
            width = memory_pkg::ldst_width_t'(rnd[10:8] % 3'd7);
            addr  = {hi[63:11], 4'b0000, rnd[19:16], rnd[22:20]};
            access(rnd[0] ? memory_pkg::LSU_STORE : memory_pkg::LSU_LOAD, width, addr,
                   next_random(), next_random());
        end
        drain();

        assert_fails = uut.u_checker.fail_count;
        $display("Checked: %0d, value errors: %0d, protocol errors: %0d, assertion failures: %0d",
                 n_checked, value_errors, proto_errors, assert_fails);
        if (value_errors + proto_errors + assert_fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+source
source/memory_pkg.sv
source/expipe_pkg.sv
source/byte_selector.sv
source/address_gen.sv
source/dmem_stage.sv
source/load_writeback.sv
source/load_store_pipe.sv
tests/load_store_pipe_checker.sv
tests/tb_load_store_pipe.sv

// ==== Bender.yml ====
package:
  name: load_store_pipe

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/memory_pkg.sv
      - source/expipe_pkg.sv
      - source/byte_selector.sv
      - source/address_gen.sv
      - source/dmem_stage.sv
      - source/load_writeback.sv
      - source/load_store_pipe.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/load_store_pipe_checker.sv
      - tests/tb_load_store_pipe.sv
